// File: design/rv_decode_cfg.svh
`ifndef RV_DECODE_CFG_SVH
`define RV_DECODE_CFG_SVH

// register and operand width
`define XLEN 64

// general registers, x0 included
`define NR_REG 32

// index width for rd, rs1, rs2
`define REG_SEL 5

// first fetch address after reset
`define RESET_PC 64'h8000_0000

`endif

// File: design/rv_decode_pkg.sv
`include "rv_decode_cfg.svh"

package rv_decode_pkg;

	// I layout, also used for jalr and ebreak
	typedef struct packed {
		logic [11:0]         imm12;
		logic [`REG_SEL-1:0] rs1;
		logic [2:0]          funct3;
		logic [`REG_SEL-1:0] rd;
		logic [6:0]          opcode;
	} i_fmt_t;

	// store layout, immediate split around rs2/rs1
	typedef struct packed {
		logic [6:0]          imm_hi;
		logic [`REG_SEL-1:0] rs2;
		logic [`REG_SEL-1:0] rs1;
		logic [2:0]          funct3;
		logic [4:0]          imm_lo;
		logic [6:0]          opcode;
	} s_fmt_t;

	typedef struct packed {
		logic [19:0]         imm20; // upper 20 bits of the value
		logic [`REG_SEL-1:0] rd;
		logic [6:0]          opcode;
	} u_fmt_t;

	// jump offset bits as they sit in the word
	typedef struct packed {
		logic                imm_20;
		logic [9:0]          imm_10_1;
		logic                imm_11;
		logic [7:0]          imm_19_12;
		logic [`REG_SEL-1:0] rd;
		logic [6:0]          opcode;
	} j_fmt_t;

	// one instruction word, four readings
	typedef union packed {
		i_fmt_t i_fmt;
		s_fmt_t s_fmt;
		u_fmt_t u_fmt;
		j_fmt_t j_fmt;
	} inst_u;

	typedef enum logic [2:0] {
		op_addi   = 3'd0,
		op_jalr   = 3'd1,
		op_auipc  = 3'd2,
		op_lui    = 3'd3,
		op_sd     = 3'd4,
		op_jal    = 3'd5,
		op_ebreak = 3'd6,
		op_none   = 3'd7
	} op_e;

	typedef enum logic [2:0] {
		fmt_i,
		fmt_s,
		fmt_u,
		fmt_j,
		fmt_none
	} fmt_e;

	typedef struct packed {
		op_e                 op;
		fmt_e                fmt;
		logic [`REG_SEL-1:0] rd;
		logic [`REG_SEL-1:0] rs1;
		logic [`REG_SEL-1:0] rs2;
		logic [`XLEN-1:0]    imm;    // already sign-extended and shifted
		logic                rd_wen;
		logic                illegal;
	} dec_t;

	// write-back request toward the register array
	typedef struct packed {
		logic                en;
		logic [`REG_SEL-1:0] rd;
		logic [`XLEN-1:0]    data;
	} wb_t;

endpackage

// File: design/inst_decoder.sv
`include "rv_decode_cfg.svh"

module inst_decoder (
	input  rv_decode_pkg::inst_u inst,
	output rv_decode_pkg::dec_t  dec
);
	import rv_decode_pkg::*;

	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
	localparam logic [6:0] OPC_JALR   = 7'b1100111;
	localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
	localparam logic [6:0] OPC_LUI    = 7'b0110111;
	localparam logic [6:0] OPC_STORE  = 7'b0100011;
	localparam logic [6:0] OPC_JAL    = 7'b1101111;
	localparam logic [31:0] EBREAK_WORD = 32'h0010_0073;

	logic [`XLEN-1:0] imm_i;
	logic [`XLEN-1:0] imm_s;
	logic [`XLEN-1:0] imm_u;
	logic [`XLEN-1:0] imm_j;

	assign imm_i = {{(`XLEN-12){inst.i_fmt.imm12[11]}}, inst.i_fmt.imm12};
	assign imm_s = {{(`XLEN-12){inst.s_fmt.imm_hi[6]}}, inst.s_fmt.imm_hi, inst.s_fmt.imm_lo};
	assign imm_u = {{(`XLEN-32){inst.u_fmt.imm20[19]}}, inst.u_fmt.imm20, 12'b0};

	// unscramble the jump offset, bit 0 is implied zero
	assign imm_j = {{(`XLEN-21){inst.j_fmt.imm_20}}, inst.j_fmt.imm_20,
		inst.j_fmt.imm_19_12, inst.j_fmt.imm_11, inst.j_fmt.imm_10_1, 1'b0};

	always_comb begin
		dec.op      = op_none;
		dec.fmt     = fmt_none;
		dec.rd      = inst.i_fmt.rd;
		dec.rs1     = inst.i_fmt.rs1;
		dec.rs2     = inst.s_fmt.rs2;
		dec.imm     = '0;
		dec.rd_wen  = 1'b0;
		dec.illegal = 1'b1; // cleared on any match below

		case (inst.i_fmt.opcode)
			OPC_OP_IMM: if (inst.i_fmt.funct3 == 3'b000) begin
				dec.op      = op_addi;
				dec.fmt     = fmt_i;
				dec.imm     = imm_i;
				dec.illegal = 1'b0;
			end
			OPC_JALR: if (inst.i_fmt.funct3 == 3'b000) begin
				dec.op      = op_jalr;
				dec.fmt     = fmt_i;
				dec.imm     = imm_i;
				dec.illegal = 1'b0;
			end
			OPC_AUIPC: begin
				dec.op      = op_auipc;
				dec.fmt     = fmt_u;
				dec.imm     = imm_u;
				dec.illegal = 1'b0;
			end
			OPC_LUI: begin
				dec.op      = op_lui;
				dec.fmt     = fmt_u;
				dec.imm     = imm_u;
				dec.illegal = 1'b0;
			end
			OPC_STORE: if (inst.s_fmt.funct3 == 3'b011) begin // doubleword only
				dec.op      = op_sd;
				dec.fmt     = fmt_s;
				dec.imm     = imm_s;
				dec.illegal = 1'b0;
			end
			OPC_JAL: begin
				dec.op      = op_jal;
				dec.fmt     = fmt_j;
				dec.imm     = imm_j;
				dec.illegal = 1'b0;
			end
			default: if (inst == EBREAK_WORD) begin
				dec.op      = op_ebreak;
				dec.illegal = 1'b0;
			end
		endcase

		// sd and ebreak leave the register file alone
		dec.rd_wen = (dec.op == op_addi) || (dec.op == op_jalr) || (dec.op == op_auipc) ||
			(dec.op == op_lui) || (dec.op == op_jal);
	end

	always_comb begin
		a_illegal_op: assert #0 (dec.illegal == (dec.op == op_none))
			else $error("illegal flag out of step with op %0d", dec.op);
	end

endmodule

// File: design/wb_steer.sv
`include "rv_decode_cfg.svh"

module wb_steer (
	input  logic                clk,
	input  logic                rst_n,
	input  rv_decode_pkg::wb_t  wb,
	output logic [`NR_REG-1:0]  wen,
	output logic [`XLEN-1:0]    wdata
);
	import rv_decode_pkg::*;

	// one comparator per register, x0 has none so it stays zero
	always_comb begin
		wen = '0;
		for (int i = 1; i < `NR_REG; i++) begin
			wen[i] = rst_n && wb.en && (wb.rd == `REG_SEL'(i));
		end
	end

	// every cell sees the same data word
	assign wdata = wb.data;

	a_strobe_onehot: assert property (
		@(posedge clk) disable iff (!rst_n)
		$onehot0(wen)
	) else $error("bad write strobe %h", wen);

endmodule

// File: design/gpr_cell.sv
`include "rv_decode_cfg.svh"

module gpr_cell (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             wen,
	input  logic [`XLEN-1:0] wdata,
	output logic [`XLEN-1:0] q
);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			q <= '0;
		end else if (wen) begin
			q <= wdata;
		end
	end

	// value only moves on its own strobe
	a_hold_without_wen: assert property (
		@(posedge clk) disable iff (!rst_n)
		!wen |=> $stable(q)
	) else $error("register changed without write strobe");

endmodule

// File: design/operand_select.sv
`include "rv_decode_cfg.svh"

module operand_select (
	input  rv_decode_pkg::dec_t dec,
	input  logic [`XLEN-1:0]    regs [`NR_REG],
	output logic [`XLEN-1:0]    src1,
	output logic [`XLEN-1:0]    src2
);
	import rv_decode_pkg::*;

	logic [`XLEN-1:0] rs1_val;
	logic [`XLEN-1:0] rs2_val;

	// register array read ports
	assign rs1_val = regs[dec.rs1];
	assign rs2_val = regs[dec.rs2];

	always_comb begin
		src1 = '0;
		src2 = '0;
		case (dec.fmt)
			fmt_i: begin
				src1 = rs1_val;
				src2 = dec.imm;
			end
			fmt_s: begin
				// store base and store data
				src1 = rs1_val;
				src2 = rs2_val;
			end
			fmt_u, fmt_j: begin
				src1 = dec.imm; // offset or upper immediate
			end
			default: begin
				// ebreak and unknown words carry no operands
				src1 = '0;
				src2 = '0;
			end
		endcase
	end

endmodule

// File: design/exec_unit.sv
`include "rv_decode_cfg.svh"

module exec_unit (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                inst_valid,
	input  rv_decode_pkg::dec_t dec,
	input  logic [`XLEN-1:0]    src1,
	input  logic [`XLEN-1:0]    src2,
	output rv_decode_pkg::wb_t  wb,
	output logic [`XLEN-1:0]    pc,
	output logic                halt
);
	import rv_decode_pkg::*;

	logic [`XLEN-1:0] pc_plus4;
	logic [`XLEN-1:0] pc_next;
	logic [`XLEN-1:0] wb_val;
	logic             run;

	assign pc_plus4 = pc + `XLEN'd4;
	assign run      = inst_valid && !halt;

	// write-back value by op
	always_comb begin
		case (dec.op)
			op_addi:         wb_val = src1 + src2;
			op_lui:          wb_val = src1;
			op_auipc:        wb_val = pc + src1;
			op_jal, op_jalr: wb_val = pc_plus4; // link address
			default:         wb_val = '0;
		endcase
	end

	always_comb begin
		case (dec.op)
			op_jal:    pc_next = pc + src1;
			op_jalr:   pc_next = (src1 + src2) & ~`XLEN'd1;
			op_ebreak: pc_next = pc;
			op_none:   pc_next = pc; // unknown word, nothing moves
			default:   pc_next = pc_plus4;
		endcase
	end

	assign wb.en   = dec.rd_wen && run;
	assign wb.rd   = dec.rd;
	assign wb.data = wb_val;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pc   <= `RESET_PC;
			halt <= 1'b0;
		end else if (run) begin
			pc <= pc_next;
			if (dec.op == op_ebreak) begin
				halt <= 1'b1;
			end
		end
	end

	// once halted, only reset gets the core moving again
	a_halt_freezes: assert property (
		@(posedge clk) disable iff (!rst_n)
		halt |=> halt && $stable(pc)
	) else $error("pc moved after halt");

endmodule

// File: design/rv_decode_core.sv
`include "rv_decode_cfg.svh"

module rv_decode_core (
	input  logic                clk,
	input  logic                rst_n,
	input  logic [31:0]         inst,
	input  logic                inst_valid,
	output logic [`XLEN-1:0]    src1,
	output logic [`XLEN-1:0]    src2,
	output rv_decode_pkg::op_e  func,
	output logic [`XLEN-1:0]    pc,
	output logic                halt,
	output logic                illegal
);
	import rv_decode_pkg::*;

	inst_u            inst_w;
	dec_t             dec;
	wb_t              wb;
	logic [`NR_REG-1:0] wen;
	logic [`XLEN-1:0] wdata;
	logic [`XLEN-1:0] regs [`NR_REG];

	assign inst_w  = inst;
	assign func    = dec.op;
	assign illegal = dec.illegal;

	inst_decoder u_decoder (
		.inst (inst_w),
		.dec  (dec)
	);

	wb_steer u_steer (
		.clk   (clk),
		.rst_n (rst_n),
		.wb    (wb),
		.wen   (wen),
		.wdata (wdata)
	);

	// x0 is a cell too, its strobe never fires
	for (genvar i = 0; i < `NR_REG; i++) begin : g_gpr
		gpr_cell u_cell (
			.clk   (clk),
			.rst_n (rst_n),
			.wen   (wen[i]),
			.wdata (wdata),
			.q     (regs[i])
		);
	end

	operand_select u_opsel (
		.dec  (dec),
		.regs (regs),
		.src1 (src1),
		.src2 (src2)
	);

	exec_unit u_exec (
		.clk        (clk),
		.rst_n      (rst_n),
		.inst_valid (inst_valid),
		.dec        (dec),
		.src1       (src1),
		.src2       (src2),
		.wb         (wb),
		.pc         (pc),
		.halt       (halt)
	);

endmodule

// File: verif/tb_rv_decode.sv
`include "rv_decode_cfg.svh"

module tb_rv_decode;
	import rv_decode_pkg::*;

	localparam int PERIOD     = 4;
	localparam int RST_CYCLES = 3;
	localparam int N_RAND     = 48; // random addi instructions, each followed by a read-back
	localparam int MARGIN     = 40;

	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
	localparam logic [6:0] OPC_JALR   = 7'b1100111;
	localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
	localparam logic [6:0] OPC_LUI    = 7'b0110111;
	localparam logic [6:0] OPC_STORE  = 7'b0100011;
	localparam logic [6:0] OPC_JAL    = 7'b1101111;
	localparam logic [31:0] EBREAK    = 32'h0010_0073;
	localparam logic [`XLEN-1:0] P    = `RESET_PC;

	// one program step with its expected responses
	typedef struct packed {
		logic [31:0]      inst;
		logic             valid;
		logic [`XLEN-1:0] src1;
		logic [`XLEN-1:0] src2;
		op_e              func;
		logic             illegal;
		logic [`XLEN-1:0] pc; // after the edge
	} row_t;

	logic             clk;
	logic             rst_n;
	logic [31:0]      inst;
	logic             inst_valid;
	logic [`XLEN-1:0] src1;
	logic [`XLEN-1:0] src2;
	op_e              func;
	logic [`XLEN-1:0] pc;
	logic             halt;
	logic             illegal;

	row_t             prog [$];
	logic [`XLEN-1:0] model [`NR_REG];
	logic [31:0]      lfsr = 32'h58dc;
	int               n_errors = 0;
	int               n_checks = 0;

	rv_decode_core u_dut (
		.clk        (clk),
		.rst_n      (rst_n),
		.inst       (inst),
		.inst_valid (inst_valid),
		.src1       (src1),
		.src2       (src2),
		.func       (func),
		.pc         (pc),
		.halt       (halt),
		.illegal    (illegal)
	);

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	function automatic logic [31:0] i_word(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
		logic [4:0] rd, logic [6:0] opc);
		return {imm, rs1, f3, rd, opc};
	endfunction

	function automatic logic [31:0] s_word(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1);
		return {imm[11:5], rs2, rs1, 3'b011, imm[4:0], OPC_STORE};
	endfunction

	function automatic logic [31:0] u_word(logic [19:0] imm, logic [4:0] rd, logic [6:0] opc);
		return {imm, rd, opc};
	endfunction

	// offset is a byte offset, bit 0 dropped
	function automatic logic [31:0] j_word(logic [20:0] off, logic [4:0] rd);
		return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
	endfunction

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic draw(input int n, output logic [31:0] v);
		v = '0;
		for (int b = 0; b < n; b++) begin
			lfsr = lfsr_next(lfsr);
			v = {v[30:0], lfsr[0]};
		end
	endtask

	task automatic check(input string name, input logic [`XLEN-1:0] got,
		input logic [`XLEN-1:0] exp);
		n_checks++;
		if (got !== exp) begin
			n_errors++;
			$display("Error at %0t: %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic add_row(input logic [31:0] w, input logic v, input logic [`XLEN-1:0] s1,
		input logic [`XLEN-1:0] s2, input op_e f, input logic ill, input logic [`XLEN-1:0] npc);
		row_t r;
		r = '{inst: w, valid: v, src1: s1, src2: s2, func: f, illegal: ill, pc: npc};
		prog.push_back(r);
	endtask

	// entered 1 time unit after a rising edge, left at the same point one cycle later
	task automatic run_step(input row_t r, input string tag);
		inst       = r.inst;
		inst_valid = r.valid;
		#2;
		check({tag, " src1"}, src1, r.src1);
		check({tag, " src2"}, src2, r.src2);
		check({tag, " func"}, {61'd0, func}, {61'd0, r.func});
		check({tag, " illegal"}, {63'd0, illegal}, {63'd0, r.illegal});
		@(posedge clk);
		#1;
		check({tag, " pc"}, pc, r.pc);
	endtask

	task automatic apply_reset();
		rst_n      = 1'b0;
		inst_valid = 1'b0;
		repeat (RST_CYCLES) @(posedge clk);
		#1;
		rst_n = 1'b1;
		check("pc after reset", pc, P);
		check("halt after reset", {63'd0, halt}, '0);
	endtask

	task automatic build_program();
		add_row(i_word(12'h000, 5'd7, 3'b000, 5'd3, OPC_OP_IMM), 1, 0, 0, op_addi, 0, P + 'h04);
		add_row(u_word(20'h12345, 5'd1, OPC_LUI), 1, 64'h1234_5000, 0, op_lui, 0, P + 'h08);
		add_row(i_word(12'h678, 5'd1, 3'b000, 5'd2, OPC_OP_IMM), 1, 64'h1234_5000, 64'h678,
			op_addi, 0, P + 'h0c);
		add_row(i_word(12'hfff, 5'd2, 3'b000, 5'd4, OPC_OP_IMM), 1, 64'h1234_5678, '1,
			op_addi, 0, P + 'h10);
		add_row(u_word(20'h80000, 5'd5, OPC_LUI), 1, 64'hffff_ffff_8000_0000, 0, op_lui, 0,
			P + 'h14);
		add_row(u_word(20'h00001, 5'd6, OPC_AUIPC), 1, 64'h1000, 0, op_auipc, 0, P + 'h18);
		add_row(i_word(12'h000, 5'd6, 3'b000, 5'd7, OPC_OP_IMM), 1, 64'h8000_1014, 0,
			op_addi, 0, P + 'h1c);
		// write to x0 must vanish
		add_row(i_word(12'h005, 5'd2, 3'b000, 5'd0, OPC_OP_IMM), 1, 64'h1234_5678, 5,
			op_addi, 0, P + 'h20);
		add_row(i_word(12'h000, 5'd0, 3'b000, 5'd8, OPC_OP_IMM), 1, 0, 0, op_addi, 0, P + 'h24);
		// sd x2, 2(x4), imm_lo lands on the rd field of x2
		add_row(s_word(12'h002, 5'd2, 5'd4), 1, 64'h1234_5677, 64'h1234_5678, op_sd, 0,
			P + 'h28);
		add_row(j_word(21'd16, 5'd9), 1, 64'h10, 0, op_jal, 0, P + 'h38);
		add_row(i_word(12'h000, 5'd9, 3'b000, 5'd10, OPC_OP_IMM), 1, P + 'h2c, 0, op_addi, 0,
			P + 'h3c);
		add_row(i_word(12'h003, 5'd7, 3'b000, 5'd11, OPC_JALR), 1, 64'h8000_1014, 3, op_jalr,
			0, 64'h8000_1016);
		add_row(i_word(12'h000, 5'd11, 3'b000, 5'd12, OPC_OP_IMM), 1, P + 'h40, 0, op_addi, 0,
			64'h8000_101a);
		// op-imm with funct3 1 is not decoded
		add_row(i_word(12'h000, 5'd2, 3'b001, 5'd1, OPC_OP_IMM), 1, 0, 0, op_none, 1,
			64'h8000_101a);
		add_row(i_word(12'h055, 5'd0, 3'b000, 5'd1, OPC_OP_IMM), 0, 0, 64'h55, op_addi, 0,
			64'h8000_101a); // not valid
		add_row(i_word(12'h000, 5'd1, 3'b000, 5'd13, OPC_OP_IMM), 1, 64'h1234_5000, 0,
			op_addi, 0, 64'h8000_101e);
		add_row(j_word(-21'sd8, 5'd0), 1, 64'hffff_ffff_ffff_fff8, 0, op_jal, 0, 64'h8000_1016);
		add_row(EBREAK, 1, 0, 0, op_ebreak, 0, 64'h8000_1016);
		// halted from here on
		add_row(i_word(12'h001, 5'd2, 3'b000, 5'd14, OPC_OP_IMM), 1, 64'h1234_5678, 1,
			op_addi, 0, 64'h8000_1016);
		add_row(u_word(20'habcde, 5'd2, OPC_LUI), 1, 64'hffff_ffff_abcd_e000, 0, op_lui, 0,
			64'h8000_1016);
		add_row(i_word(12'h000, 5'd2, 3'b000, 5'd15, OPC_OP_IMM), 1, 64'h1234_5678, 0,
			op_addi, 0, 64'h8000_1016);
		add_row(i_word(12'h000, 5'd14, 3'b000, 5'd16, OPC_OP_IMM), 1, 0, 0, op_addi, 0,
			64'h8000_1016);
	endtask

	// addi chain against the register model, every result read back through x0
	task automatic run_random();
		logic [31:0]      v;
		logic [11:0]      imm;
		logic [4:0]       rs1;
		logic [4:0]       rd;
		logic [`XLEN-1:0] sext;
		logic [`XLEN-1:0] exp_pc;
		row_t             r;
		for (int i = 0; i < `NR_REG; i++) model[i] = '0;
		exp_pc = P;
		for (int k = 0; k < N_RAND; k++) begin
			draw(12, v);
			imm = v[11:0];
			draw(5, v);
			rs1 = v[4:0];
			draw(5, v);
			rd = v[4:0];
			sext = {{(`XLEN-12){imm[11]}}, imm};
			exp_pc = exp_pc + 4;
			r = '{inst: i_word(imm, rs1, 3'b000, rd, OPC_OP_IMM), valid: 1'b1,
				src1: model[rs1], src2: sext, func: op_addi, illegal: 1'b0, pc: exp_pc};
			run_step(r, $sformatf("rand %0d", k));
			if (rd != 0) model[rd] = model[rs1] + sext;
			exp_pc = exp_pc + 4;
			r = '{inst: i_word(12'h000, rd, 3'b000, 5'd0, OPC_OP_IMM), valid: 1'b1,
				src1: model[rd], src2: '0, func: op_addi, illegal: 1'b0, pc: exp_pc};
			run_step(r, $sformatf("read x%0d", rd));
		end
	endtask

	initial begin
		int limit;
		#1;
		limit = (prog.size() + 2 * N_RAND + 2 * RST_CYCLES + MARGIN) * PERIOD;
		#(limit);
		$display("timeout: run did not finish within %0d time units", limit);
		$display("** FAIL **");
		$finish;
	end

	initial begin
		rst_n      = 1'b0;
		inst       = 32'h0000_0013; // addi x0, x0, 0
		inst_valid = 1'b0;
		build_program();
		apply_reset();
		foreach (prog[i]) begin
			run_step(prog[i], $sformatf("row %0d", i));
		end
		check("halt after ebreak", {63'd0, halt}, 1);
		apply_reset();
		run_random();
		$display("checks: %0d, errors: %0d", n_checks, n_errors);
		if (n_errors == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

// File: rv_decode.f
+incdir+design
design/rv_decode_pkg.sv
design/inst_decoder.sv
design/wb_steer.sv
design/gpr_cell.sv
design/operand_select.sv
design/exec_unit.sv
design/rv_decode_core.sv
verif/tb_rv_decode.sv

// File: Bender.yml
package:
  name: rv_decode

sources:
  - include_dirs:
      - design
    files:
      - design/rv_decode_pkg.sv
      - design/inst_decoder.sv
      - design/wb_steer.sv
      - design/gpr_cell.sv
      - design/operand_select.sv
      - design/exec_unit.sv
      - design/rv_decode_core.sv
  - target: test
    include_dirs:
      - design
    files:
      - verif/tb_rv_decode.sv
